// File: sim.f
hdl/cache_pkg.sv
hdl/line_beat_counter.sv
hdl/tag_state_array.sv
hdl/data_array.sv
hdl/cache_ctrl_fsm.sv
hdl/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, and scan the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_cache -o tb_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cache_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Testbench failed" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: dv/tb_cache.sv
// Directed tests for the two-way L1 data cache with a behavioral main memory
// Addresses assume NUM_SETS = 8 with the set index in bits 6:4 and the tag from bit 7 up

module tb_cache;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED    = 32'h13b6_72ee;
  localparam int          TIMEOUT = 400;

  logic clk;
  logic reset;
  logic req_val, req_rdy, resp_val, resp_rdy;
  logic mem_req_val, mem_req_rdy, mem_resp_val, mem_resp_rdy;
  cache_pkg::cache_req_t  req;
  cache_pkg::cache_resp_t resp;
  cache_pkg::mem_req_t    mem_req;
  cache_pkg::mem_resp_t   mem_resp;
  logic [1:0] mem_stall;
  logic       stall_on;
  int         read_count, write_count;
  cache_pkg::mem_req_t [3:0] wr_log;

  int          cycle = 0;
  logic [31:0] lfsr_q = SEED;
  logic [31:0] stall_lfsr = SEED;
  cache_pkg::word_t ref_mem [cache_pkg::addr_t];

  cache_top #(.NUM_SETS(8)) dut0 (.*);

  mem_model mem0 (.clk, .reset, .mem_req_val, .mem_req_rdy, .mem_req, .mem_resp_val,
    .mem_resp_rdy, .mem_resp, .stall(mem_stall), .read_count, .write_count, .wr_log);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // One LFSR bit per memory stall line
  always @(posedge clk) begin
    mem_stall[0] <= stall_on && stall_lfsr[0];
    stall_lfsr = lfsr_next(stall_lfsr);
    mem_stall[1] <= stall_on && stall_lfsr[0];
    stall_lfsr = lfsr_next(stall_lfsr);
  end

  // ------------------------------------------------------------
  // Random bits and the reference memory
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic cache_pkg::word_t ref_word(input cache_pkg::addr_t addr);
    cache_pkg::addr_t waddr;
    waddr = addr >> 2;
    if (ref_mem.exists(waddr))
      return ref_mem[waddr];
    return waddr ^ 32'hA5A5_0000;
  endfunction

  // ------------------------------------------------------------
  // Failure handling and compare tasks
  task automatic end_in_failure();
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_plain(input string why);
    $display("Error: %s", why);
    end_in_failure();
  endtask

  task automatic check_resp(input string name, input cache_pkg::cache_resp_t exp,
                            input cache_pkg::cache_resp_t act, input bit with_data);
    if (act.op !== exp.op || (with_data && act.data !== exp.data)) begin
      $display("[FAIL] %s: expected op %0d data %h, actual op %0d data %h",
               name, exp.op, exp.data, act.op, act.data);
      end_in_failure();
    end
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end_in_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      end_in_failure();
    end
  endtask

  // ------------------------------------------------------------
  // Request and response handshakes
  task automatic do_req(input cache_pkg::cache_op_e op, input cache_pkg::addr_t addr,
                        input cache_pkg::word_t data, output int accept_cycle);
    int waited;
    waited = 0;
    req_val <= 1'b1;
    req     <= '{op: op, addr: addr, data: data};
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT)
        fail_plain("the cache never accepted a request");
    end while (!req_rdy);
    accept_cycle = cycle;
    req_val <= 1'b0;
  endtask

  task automatic get_resp(input bit stall, output cache_pkg::cache_resp_t got,
                          output int resp_cycle);
    int waited;
    bit done;
    waited = 0;
    done = 1'b0;
    resp_rdy <= stall ? rand_bit() : 1'b1;
    while (!done) begin
      @(posedge clk);
      waited++;
      if (resp_val && resp_rdy) begin
        done = 1'b1;
      end else begin
        if (waited > TIMEOUT)
          fail_plain("the cache never sent a response");
        resp_rdy <= stall ? rand_bit() : 1'b1;
      end
    end
    got = resp;
    resp_cycle = cycle;
    resp_rdy <= 1'b0;
  endtask

  // One access checked against the reference memory
  task automatic access(input string name, input cache_pkg::cache_op_e op,
                        input cache_pkg::addr_t addr, input cache_pkg::word_t data,
                        input bit stall);
    cache_pkg::cache_resp_t exp, got;
    int t0, t1;
    exp = '{op: op, data: ref_word(addr)};
    do_req(op, addr, data, t0);
    get_resp(stall, got, t1);
    check_resp(name, exp, got, op == cache_pkg::CACHE_READ);
    if (op == cache_pkg::CACHE_WRITE)
      ref_mem[addr >> 2] = data;
  endtask

  // ------------------------------------------------------------
  // Directed tests
  task automatic cold_read_miss();
    int r0, w0;
    r0 = read_count;
    w0 = write_count;
    access("cold_miss", cache_pkg::CACHE_READ, 32'h0000_1004, '0, 1'b0);
    check_count("cold_miss line reads", r0 + 1, read_count);
    check_count("cold_miss write beats", w0, write_count);
  endtask

  task automatic write_then_read();
    access("write_read hit write", cache_pkg::CACHE_WRITE, 32'h0000_1008, 32'hCAFE_0001, 1'b0);
    access("write_read hit read", cache_pkg::CACHE_READ, 32'h0000_1008, '0, 1'b0);
    access("write_read miss write", cache_pkg::CACHE_WRITE, 32'h0000_2014, 32'h0BAD_F00D, 1'b0);
    access("write_read miss read", cache_pkg::CACHE_READ, 32'h0000_2014, '0, 1'b0);
  endtask

  task automatic hit_latency();
    cache_pkg::cache_resp_t exp, got;
    int r0, w0, t0, t1;
    r0 = read_count;
    w0 = write_count;
    exp = '{op: cache_pkg::CACHE_READ, data: ref_word(32'h0000_1004)};
    do_req(cache_pkg::CACHE_READ, 32'h0000_1004, '0, t0);
    get_resp(1'b0, got, t1);
    check_resp("hit_latency data", exp, got, 1'b1);
    check_count("hit_latency cycles", 3, t1 - t0);
    check_count("hit_latency line reads", r0, read_count);
    check_count("hit_latency write beats", w0, write_count);
  endtask

  task automatic lru_victim_choice();
    int r0;
    access("lru read A", cache_pkg::CACHE_READ, 32'h0000_3020, '0, 1'b0);
    access("lru read B", cache_pkg::CACHE_READ, 32'h0000_30A0, '0, 1'b0);
    access("lru touch A", cache_pkg::CACHE_READ, 32'h0000_3020, '0, 1'b0);
    access("lru read C", cache_pkg::CACHE_READ, 32'h0000_3120, '0, 1'b0);
    r0 = read_count;
    access("lru reread A", cache_pkg::CACHE_READ, 32'h0000_3020, '0, 1'b0);
    check_count("lru A still cached", r0, read_count);
    access("lru reread B", cache_pkg::CACHE_READ, 32'h0000_30A0, '0, 1'b0);
    check_count("lru B was evicted", r0 + 1, read_count);
  endtask

  task automatic dirty_writeback();
    int w0;
    access("wb write D", cache_pkg::CACHE_WRITE, 32'h0000_4054, 32'h1111_2222, 1'b0);
    access("wb write E", cache_pkg::CACHE_WRITE, 32'h0000_40D8, 32'h3333_4444, 1'b0);
    w0 = write_count;
    access("wb write F", cache_pkg::CACHE_WRITE, 32'h0000_4150, 32'h5555_6666, 1'b0);
    check_count("wb write beats", w0 + 4, write_count);
    // Oldest beat sits at the top of the log
    for (int k = 0; k < 4; k++) begin
      check_word("wb beat address", 32'h0000_4050 + 4 * k, wr_log[3 - k].addr);
      check_word("wb beat data", ref_word(32'h0000_4050 + 4 * k), wr_log[3 - k].data);
    end
    access("wb reread D", cache_pkg::CACHE_READ, 32'h0000_4054, '0, 1'b0);
  endtask

  task automatic back_pressure();
    cache_pkg::addr_t addr;
    cache_pkg::cache_op_e op;
    stall_on <= 1'b1;
    for (int i = 0; i < 60; i++) begin
      addr = 32'h0000_8000 | (rand_bits(2) << 7) | (rand_bits(2) << 4) | (rand_bits(2) << 2);
      op = rand_bit() ? cache_pkg::CACHE_WRITE : cache_pkg::CACHE_READ;
      access("back_pressure", op, addr, rand_bits(32), 1'b1);
    end
    stall_on <= 1'b0;
  endtask

  // ------------------------------------------------------------
  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req      = '0;
    resp_rdy = 1'b0;
    stall_on = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (!req_rdy || resp_val || mem_req_val || mem_resp_rdy)
      fail_plain("handshake outputs are wrong after reset");
    cold_read_miss();
    write_then_read();
    hit_latency();
    lru_victim_choice();
    dirty_writeback();
    back_pressure();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: dv/mem_model.sv
// Word-addressed main memory behind the cache, initial word = word address ^ 32'hA5A5_0000
// Stall bits come from the testbench; a raised response valid holds until the handshake

module mem_model (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          mem_req_val,
  output logic                          mem_req_rdy,
  input  cache_pkg::mem_req_t           mem_req,
  output logic                          mem_resp_val,
  input  logic                          mem_resp_rdy,
  output cache_pkg::mem_resp_t          mem_resp,
  input  logic [1:0]                    stall,
  output int                            read_count,
  output int                            write_count,
  output cache_pkg::mem_req_t [3:0]     wr_log
);

  timeunit 1ns;
  timeprecision 1ps;

  cache_pkg::word_t store [cache_pkg::addr_t];
  cache_pkg::word_t resp_q [$];
  int               wr_beats;

  function automatic cache_pkg::word_t read_word(input cache_pkg::addr_t waddr);
    if (store.exists(waddr))
      return store[waddr];
    return waddr ^ 32'hA5A5_0000;
  endfunction

  always @(posedge clk) begin
    cache_pkg::addr_t waddr;
    if (reset) begin
      store.delete();
      resp_q.delete();
      wr_beats = 0;
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
      mem_resp     <= '0;
      read_count   <= 0;
      write_count  <= 0;
      wr_log       <= '0;
    end else begin
      if (mem_resp_val && mem_resp_rdy)
        void'(resp_q.pop_front());
      if (mem_req_val && mem_req_rdy) begin
        waddr = mem_req.addr >> 2;
        if (mem_req.op == cache_pkg::MEM_WRITE_WORD) begin
          store[waddr] = mem_req.data;
          wr_log      <= {wr_log[2:0], mem_req};
          write_count <= write_count + 1;
          wr_beats++;
          // One acknowledge per writeback line
          if (wr_beats == cache_pkg::WORDS_PER_LINE) begin
            wr_beats = 0;
            resp_q.push_back('0);
          end
        end else begin
          read_count <= read_count + 1;
          for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++)
            resp_q.push_back(read_word(waddr + k));
        end
      end
      mem_req_rdy  <= !stall[0];
      mem_resp_val <= (resp_q.size() != 0) && ((mem_resp_val && !mem_resp_rdy) || !stall[1]);
      if (resp_q.size() != 0)
        mem_resp <= '{data: resp_q[0]};
    end
  end

endmodule

// File: hdl/cache_top.sv
// Blocking two-way write-back L1 data cache, one request in flight
// NUM_SETS must be a power of two, at least 2

module cache_top #(
  parameter int NUM_SETS = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  output logic                   req_rdy,
  input  cache_pkg::cache_req_t  req,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output cache_pkg::cache_resp_t resp,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  output cache_pkg::mem_req_t    mem_req,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy,
  input  cache_pkg::mem_resp_t   mem_resp
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFFSET_W - 2;

  cache_pkg::cache_op_e        resp_op;
  cache_pkg::mem_op_e          mem_req_op;
  cache_pkg::addr_t            mem_req_addr;
  cache_pkg::addr_t            req_addr;
  cache_pkg::word_t            req_data;
  cache_pkg::word_t            rd_word;
  cache_pkg::word_t            read_data;
  logic                        way_sel;
  logic                        tag_wen, valid_wen, dirty_wen, dirty_in, lru_wen;
  logic                        data_wen, data_from_mem, read_reg_en;
  logic [cache_pkg::OFFSET_W-1:0] word_offset;
  logic [cache_pkg::OFFSET_W-1:0] beat;
  logic                        last_beat, beat_clear, beat_step;
  logic                        hit0, hit1, dirty0, dirty1, lru_way;
  logic [TAG_W-1:0]            victim_tag;

  // Writeback beats carry the word read straight from the data array
  assign mem_req = '{op: mem_req_op, addr: mem_req_addr, data: rd_word};
  assign resp    = '{op: resp_op, data: read_data};

  cache_ctrl_fsm #(.NUM_SETS(NUM_SETS)) ctrl0 (
    .clk, .reset,
    .req_val, .req_rdy, .req,
    .resp_val, .resp_rdy, .resp_op,
    .mem_req_val, .mem_req_rdy, .mem_req_op, .mem_req_addr,
    .mem_resp_val, .mem_resp_rdy,
    .req_addr, .req_data, .way_sel,
    .tag_wen, .valid_wen, .dirty_wen, .dirty_in, .lru_wen,
    .data_wen, .data_from_mem, .read_reg_en, .word_offset,
    .hit0, .hit1, .dirty0, .dirty1, .lru_way, .victim_tag,
    .beat_clear, .beat_step, .beat, .last_beat
  );

  line_beat_counter beats0 (
    .clk, .reset,
    .clear (beat_clear),
    .step  (beat_step),
    .beat  (beat),
    .last  (last_beat)
  );

  tag_state_array #(.NUM_SETS(NUM_SETS)) tags0 (
    .clk, .reset,
    .addr (req_addr),
    .way_sel,
    .tag_wen, .valid_wen, .dirty_wen, .dirty_in, .lru_wen,
    .hit0, .hit1, .dirty0, .dirty1, .lru_way, .victim_tag
  );

  data_array #(.NUM_SETS(NUM_SETS)) data0 (
    .clk,
    .addr        (req_addr),
    .way_sel,
    .word_offset,
    .wen         (data_wen),
    .from_mem    (data_from_mem),
    .cpu_data    (req_data),
    .mem_data    (mem_resp.data),
    .read_reg_en,
    .rd_word,
    .read_data
  );

endmodule

// File: hdl/cache_ctrl_fsm.sv
// Cache controller: hit path, dirty writeback and refill
// Memory must return refill beats in offset order 0 to 3

module cache_ctrl_fsm #(
  parameter int NUM_SETS = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  cache_pkg::cache_req_t req,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output cache_pkg::cache_op_e resp_op,
  output logic                 mem_req_val,
  input  logic                 mem_req_rdy,
  output cache_pkg::mem_op_e   mem_req_op,
  output cache_pkg::addr_t     mem_req_addr,
  input  logic                 mem_resp_val,
  output logic                 mem_resp_rdy,
  output cache_pkg::addr_t     req_addr,
  output cache_pkg::word_t     req_data,
  output logic                 way_sel,
  output logic                 tag_wen,
  output logic                 valid_wen,
  output logic                 dirty_wen,
  output logic                 dirty_in,
  output logic                 lru_wen,
  output logic                 data_wen,
  output logic                 data_from_mem,
  output logic                 read_reg_en,
  output logic [cache_pkg::OFFSET_W-1:0] word_offset,
  input  logic                 hit0,
  input  logic                 hit1,
  input  logic                 dirty0,
  input  logic                 dirty1,
  input  logic                 lru_way,
  input  logic [cache_pkg::ADDR_W-$clog2(NUM_SETS)-cache_pkg::OFFSET_W-3:0] victim_tag,
  output logic                 beat_clear,
  output logic                 beat_step,
  input  logic [cache_pkg::OFFSET_W-1:0] beat,
  input  logic                 last_beat
);

  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int LINE_W = cache_pkg::OFFSET_W + 2;

  cache_pkg::ctrl_state_e state_q, state_d;
  cache_pkg::cache_req_t  req_q;
  logic                   way_q;

  logic hit;
  logic victim_dirty;
  logic [IDX_W-1:0] req_idx;
  cache_pkg::ctrl_state_e access_state;

  assign hit          = hit0 || hit1;
  assign victim_dirty = lru_way ? dirty1 : dirty0;
  assign req_idx      = req_q.addr[LINE_W +: IDX_W];
  assign access_state = (req_q.op == cache_pkg::CACHE_WRITE) ? cache_pkg::WRITE_ACCESS
                                                             : cache_pkg::READ_ACCESS;

  assign req_addr = req_q.addr;
  assign req_data = req_q.data;
  assign resp_op  = req_q.op;
  assign way_sel  = way_q;

  // ------------------------------------------------------------
  // State, request latch and way record
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= cache_pkg::IDLE;
      way_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Hit way if any, else the LRU way becomes the victim
      if (state_q == cache_pkg::TAG_CHECK)
        way_q <= hit ? hit1 : lru_way;
    end
  end

  always_ff @(posedge clk) begin
    if (req_val && req_rdy)
      req_q <= req;
  end

  // ------------------------------------------------------------
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::IDLE:
        if (req_val) state_d = cache_pkg::TAG_CHECK;
      cache_pkg::TAG_CHECK:
        if (hit)               state_d = access_state;
        else if (victim_dirty) state_d = cache_pkg::EVICT_SEND;
        else                   state_d = cache_pkg::REFILL_REQ;
      cache_pkg::READ_ACCESS,
      cache_pkg::WRITE_ACCESS:
        state_d = cache_pkg::RESP;
      cache_pkg::EVICT_SEND:
        if (mem_req_rdy && last_beat) state_d = cache_pkg::EVICT_ACK;
      cache_pkg::EVICT_ACK:
        if (mem_resp_val) state_d = cache_pkg::REFILL_REQ;
      cache_pkg::REFILL_REQ:
        if (mem_req_rdy) state_d = cache_pkg::REFILL_RECV;
      cache_pkg::REFILL_RECV:
        if (mem_resp_val && last_beat) state_d = access_state;
      cache_pkg::RESP:
        if (resp_rdy) state_d = cache_pkg::IDLE;
      default:
        state_d = cache_pkg::IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // Control outputs
  always_comb begin
    req_rdy       = (state_q == cache_pkg::IDLE);
    resp_val      = (state_q == cache_pkg::RESP);
    mem_req_val   = (state_q == cache_pkg::EVICT_SEND) || (state_q == cache_pkg::REFILL_REQ);
    mem_resp_rdy  = (state_q == cache_pkg::EVICT_ACK) || (state_q == cache_pkg::REFILL_RECV);
    tag_wen       = 1'b0;
    valid_wen     = 1'b0;
    dirty_wen     = 1'b0;
    dirty_in      = 1'b0;
    lru_wen       = 1'b0;
    data_wen      = 1'b0;
    data_from_mem = 1'b0;
    read_reg_en   = 1'b0;
    beat_clear    = (state_q == cache_pkg::TAG_CHECK);
    beat_step     = 1'b0;
    word_offset   = req_q.addr[2 +: cache_pkg::OFFSET_W];
    case (state_q)
      cache_pkg::READ_ACCESS: begin
        read_reg_en = 1'b1;
        lru_wen     = 1'b1;
      end
      cache_pkg::WRITE_ACCESS: begin
        data_wen  = 1'b1;
        dirty_wen = 1'b1;
        dirty_in  = 1'b1;
        lru_wen   = 1'b1;
      end
      cache_pkg::EVICT_SEND: begin
        word_offset = beat;
        beat_step   = mem_req_rdy;
      end
      cache_pkg::REFILL_RECV: begin
        word_offset   = beat;
        data_from_mem = 1'b1;
        data_wen      = mem_resp_val;
        beat_step     = mem_resp_val;
        // Line becomes valid and clean with the last beat
        tag_wen       = mem_resp_val && last_beat;
        valid_wen     = mem_resp_val && last_beat;
        dirty_wen     = mem_resp_val && last_beat;
      end
      default: ;
    endcase
  end

  // Writeback walks the victim line, refill asks for the request's line base
  always_comb begin
    if (state_q == cache_pkg::EVICT_SEND) begin
      mem_req_op   = cache_pkg::MEM_WRITE_WORD;
      mem_req_addr = {victim_tag, req_idx, beat, 2'b00};
    end else begin
      mem_req_op   = cache_pkg::MEM_READ_LINE;
      mem_req_addr = {req_q.addr[cache_pkg::ADDR_W-1:LINE_W], {LINE_W{1'b0}}};
    end
  end

endmodule

// File: hdl/data_array.sv
// Word storage for both ways; read data is registered for the response

module data_array #(
  parameter int NUM_SETS = 8
) (
  input  logic                           clk,
  input  cache_pkg::addr_t               addr,
  input  logic                           way_sel,
  input  logic [cache_pkg::OFFSET_W-1:0] word_offset,
  input  logic                           wen,
  input  logic                           from_mem,
  input  cache_pkg::word_t               cpu_data,
  input  cache_pkg::word_t               mem_data,
  input  logic                           read_reg_en,
  output cache_pkg::word_t               rd_word,
  output cache_pkg::word_t               read_data
);

  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int LINE_W = cache_pkg::OFFSET_W + 2;

  cache_pkg::word_t words [2][NUM_SETS][cache_pkg::WORDS_PER_LINE];

  logic [IDX_W-1:0] idx;

  assign idx     = addr[LINE_W +: IDX_W];
  // Combinational read, used for writeback beats
  assign rd_word = words[way_sel][idx][word_offset];

  always_ff @(posedge clk) begin
    if (wen)
      words[way_sel][idx][word_offset] <= from_mem ? mem_data : cpu_data;
  end

  always_ff @(posedge clk) begin
    if (read_reg_en)
      read_data <= rd_word;
  end

endmodule

// File: hdl/tag_state_array.sv
// Tags, valid, dirty and LRU state for a two-way cache
// Valid bits are only ever set; nothing invalidates a line

module tag_state_array #(
  parameter int NUM_SETS = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  cache_pkg::addr_t addr,
  input  logic             way_sel,
  input  logic             tag_wen,
  input  logic             valid_wen,
  input  logic             dirty_wen,
  input  logic             dirty_in,
  input  logic             lru_wen,
  output logic             hit0,
  output logic             hit1,
  output logic             dirty0,
  output logic             dirty1,
  output logic             lru_way,
  output logic [cache_pkg::ADDR_W-$clog2(NUM_SETS)-cache_pkg::OFFSET_W-3:0] victim_tag
);

  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int LINE_W = cache_pkg::OFFSET_W + 2;
  localparam int TAG_W  = cache_pkg::ADDR_W - IDX_W - LINE_W;

  logic [TAG_W-1:0]          tag_mem [2][NUM_SETS];
  logic [1:0][NUM_SETS-1:0]  valid_q;
  logic [1:0][NUM_SETS-1:0]  dirty_q;
  logic [NUM_SETS-1:0]       lru_q;

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] addr_tag;

  assign idx      = addr[LINE_W +: IDX_W];
  assign addr_tag = addr[cache_pkg::ADDR_W-1 -: TAG_W];

  // ------------------------------------------------------------
  // Lookup
  assign hit0       = valid_q[0][idx] && (tag_mem[0][idx] == addr_tag);
  assign hit1       = valid_q[1][idx] && (tag_mem[1][idx] == addr_tag);
  assign dirty0     = dirty_q[0][idx];
  assign dirty1     = dirty_q[1][idx];
  assign lru_way    = lru_q[idx];
  assign victim_tag = tag_mem[way_sel][idx];

  // ------------------------------------------------------------
  // Update
  always_ff @(posedge clk) begin
    if (tag_wen)
      tag_mem[way_sel][idx] <= addr_tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (valid_wen)
        valid_q[way_sel][idx] <= 1'b1;
      if (dirty_wen)
        dirty_q[way_sel][idx] <= dirty_in;
      // The way just used is most recent, so the other one is LRU
      if (lru_wen)
        lru_q[idx] <= ~way_sel;
    end
  end

endmodule

// File: hdl/line_beat_counter.sv
// Word beat counter for one cache line, wraps after the last beat

module line_beat_counter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clear,
  input  logic                           step,
  output logic [cache_pkg::OFFSET_W-1:0] beat,
  output logic                           last
);

  localparam logic [cache_pkg::OFFSET_W-1:0] LAST_BEAT =
    cache_pkg::OFFSET_W'(cache_pkg::WORDS_PER_LINE - 1);

  assign last = (beat == LAST_BEAT);

  // Clear wins over step
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      beat <= '0;
    end else if (step) begin
      if (last)
        beat <= '0;
      else
        beat <= beat + 1'b1;
    end
  end

endmodule

// File: hdl/cache_pkg.sv
// Shared widths and message formats for the L1 data cache
// Word accesses only; the two low address bits are ignored

package cache_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_W       = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic {
    CACHE_READ  = 1'b0,
    CACHE_WRITE = 1'b1
  } cache_op_e;

  typedef enum logic {
    MEM_READ_LINE  = 1'b0,
    MEM_WRITE_WORD = 1'b1
  } mem_op_e;

  // ------------------------------------------------------------
  // Processor side messages
  typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  typedef struct packed {
    cache_op_e op;
    word_t     data;
  } cache_resp_t;

  // ------------------------------------------------------------
  // Memory side messages
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    word_t   data;
  } mem_req_t;

  // One refill word, or the writeback acknowledge
  typedef struct packed {
    word_t data;
  } mem_resp_t;

  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, READ_ACCESS, WRITE_ACCESS, EVICT_SEND,
    EVICT_ACK, REFILL_REQ, REFILL_RECV, RESP
  } ctrl_state_e;

endpackage
